// ==== verilog/mips_isa_pkg.sv ====
package mips_isa_pkg;

    // ############################################################
    // Primary opcodes, bits 31..26 of the instruction.
    // ############################################################
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_t;

    // Funct codes for R-type.
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_lui
    } alu_op_t;

    // Field positions, lowest bit of each field.
    localparam int op_lsb    = 26;
    localparam int rs_lsb    = 21;
    localparam int rt_lsb    = 16;
    localparam int rd_lsb    = 11;
    localparam int shamt_lsb = 6;
    localparam int funct_lsb = 0;

    localparam logic [4:0] reg_v0 = 5'd2;  // $v0.

endpackage

// ==== verilog/mips_bus_pkg.sv ====
package mips_bus_pkg;

    // ############################################################
    // Avalon-MM widths.
    // ############################################################
    localparam int data_width = 32;
    localparam int addr_width = 32;  // Byte address.
    localparam int be_width   = 4;

    // Sequencer states.
    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_mem_read,
        st_mem_write,
        st_writeback,
        st_halted
    } seq_state_t;

    // RAM depth in words.
    localparam int mem_words_default = 256;

endpackage

// ==== verilog/mips_alu.sv ====
`timescale 1ns/10ps

module mips_alu (
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [4:0]            shamt,
    input  mips_isa_pkg::alu_op_t op,
    output logic [31:0]           result,
    output logic                  zero
);
    import mips_isa_pkg::*;

    logic lt_signed;

    assign lt_signed = $signed(a) < $signed(b);

    // ############################################################
    // Operation select.
    // ############################################################
    always_comb begin
        case (op)
            alu_add: result = a + b;   // Wraps modulo 2^32.
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_slt: result = {31'b0, lt_signed};
            alu_sll: result = b << shamt;
            alu_srl: result = b >> shamt;  // Logical, zero fill.
            alu_lui: result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // Used by BEQ and BNE.
    assign zero = (result == '0);

endmodule

// ==== verilog/mips_regfile.sv ====
`timescale 1ns/10ps

module mips_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic [4:0]  wr_addr,
    input  logic        wr_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);
    import mips_isa_pkg::*;

    logic [31:0] regs [32];

    // $0 is cleared on reset and never written.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[reg_v0];  // Exported for checking.

endmodule

// ==== verilog/mips_control.sv ====
`timescale 1ns/10ps

module mips_control #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  waitrequest,
    input  logic [mips_bus_pkg::data_width-1:0]   readdata,
    output logic [mips_bus_pkg::addr_width-1:0]   address,
    output logic                                  read,
    output logic                                  write,
    output logic [mips_bus_pkg::be_width-1:0]     byteenable,
    output logic [4:0]                            rs_addr,
    output logic [4:0]                            rt_addr,
    input  logic [31:0]                           rs_data,
    input  logic [31:0]                           rt_data,
    output mips_isa_pkg::alu_op_t                 alu_op,
    output logic                                  alu_src_imm,
    output logic                                  imm_zero_ext,
    input  logic                                  alu_zero,
    input  logic [31:0]                           alu_result,
    output logic                                  wr_en,
    output logic [4:0]                            wr_addr,
    output logic                                  wr_from_mem,
    output logic [31:0]                           ir,
    output logic                                  active
);
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;

    seq_state_t  state;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] branch_off;
    logic [31:0] mem_addr;   // LW/SW address, latched in execute.
    opcode_t     opcode;
    funct_t      funct;
    logic        writes_reg;
    logic        is_jr;
    logic        take_branch;

    assign opcode     = opcode_t'(ir[op_lsb +: 6]);
    assign funct      = funct_t'(ir[funct_lsb +: 6]);
    assign rs_addr    = ir[rs_lsb +: 5];
    assign rt_addr    = ir[rt_lsb +: 5];
    assign pc_plus4   = pc + 32'd4;
    assign branch_off = {{14{ir[15]}}, ir[15:0], 2'b00};

    // ############################################################
    // Decode.
    // ############################################################
    always_comb begin
        alu_op       = alu_add;
        alu_src_imm  = 1'b1;
        imm_zero_ext = 1'b0;
        writes_reg   = 1'b0;
        is_jr        = 1'b0;
        wr_addr      = rt_addr;  // Immediate forms and LW.
        case (opcode)
            op_special: begin
                alu_src_imm = 1'b0;
                wr_addr     = ir[rd_lsb +: 5];
                writes_reg  = 1'b1;
                case (funct)
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_jr: begin
                        is_jr      = 1'b1;
                        writes_reg = 1'b0;
                    end
                    default: writes_reg = 1'b0;  // Unsupported, acts as a nop.
                endcase
            end
            op_addiu, op_lw: writes_reg = 1'b1;
            op_andi: begin
                alu_op       = alu_and;
                imm_zero_ext = 1'b1;
                writes_reg   = 1'b1;
            end
            op_ori: begin
                alu_op       = alu_or;
                imm_zero_ext = 1'b1;
                writes_reg   = 1'b1;
            end
            op_lui: begin
                alu_op       = alu_lui;
                imm_zero_ext = 1'b1;
                writes_reg   = 1'b1;
            end
            op_beq, op_bne: begin
                alu_op      = alu_sub;  // Compare rs and rt.
                alu_src_imm = 1'b0;
            end
            default: ;
        endcase
    end

    assign take_branch = (opcode == op_beq && alu_zero) || (opcode == op_bne && !alu_zero);

    // Bus and datapath steering.
    assign read        = (state == st_fetch) || (state == st_mem_read);
    assign write       = (state == st_mem_write);
    assign address     = (state == st_fetch) ? pc : mem_addr;
    assign byteenable  = '1;
    assign wr_en       = (state == st_writeback);
    assign wr_from_mem = (opcode == op_lw);
    assign active      = (state != st_halted);

    // ############################################################
    // Sequencer.
    // ############################################################
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            pc    <= RESET_VECTOR;
        end else begin
            case (state)
                st_idle:   state <= st_fetch;
                st_fetch:  if (!waitrequest) state <= st_decode;
                st_decode: state <= st_execute;
                st_execute: begin
                    if (is_jr) begin
                        pc <= rs_data;
                    end else if (take_branch) begin
                        pc <= pc_plus4 + branch_off;  // No delay slot.
                    end else begin
                        pc <= pc_plus4;
                    end
                    if (is_jr && rs_data == '0) state <= st_halted;
                    else if (opcode == op_lw) state <= st_mem_read;
                    else if (opcode == op_sw) state <= st_mem_write;
                    else if (writes_reg) state <= st_writeback;
                    else state <= st_fetch;
                end
                st_mem_read:  if (!waitrequest) state <= st_writeback;
                st_mem_write: if (!waitrequest) state <= st_fetch;
                st_writeback: state <= st_fetch;
                default:      state <= st_halted;  // Stays halted.
            endcase
        end
    end

    // Instruction and memory address registers.
    always_ff @(posedge clk) begin
        if (state == st_fetch && !waitrequest) ir <= readdata;
        if (state == st_execute) mem_addr <= alu_result;
    end

endmodule

// ==== verilog/mips_cpu.sv ====
`timescale 1ns/10ps

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'd4
) (
    input  logic                                clk,
    input  logic                                rst,
    output logic                                active,
    output logic [31:0]                         register_v0,
    output logic [mips_bus_pkg::addr_width-1:0] address,
    output logic                                read,
    output logic                                write,
    output logic [mips_bus_pkg::data_width-1:0] writedata,
    output logic [mips_bus_pkg::be_width-1:0]   byteenable,
    input  logic                                waitrequest,
    input  logic [mips_bus_pkg::data_width-1:0] readdata
);
    import mips_isa_pkg::*;

    logic [4:0]  rs_addr, rt_addr, wr_addr;
    logic [31:0] rs_data, rt_data, wr_data;
    logic [31:0] ir, imm_ext, alu_b, alu_result, load_word;
    logic        alu_src_imm, imm_zero_ext, alu_zero;
    logic        wr_en, wr_from_mem;
    alu_op_t     alu_op;

    // ############################################################
    // Operand and writeback muxes.
    // ############################################################
    assign imm_ext   = imm_zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b     = alu_src_imm ? imm_ext : rt_data;
    assign wr_data   = wr_from_mem ? load_word : alu_result;
    assign writedata = rt_data;  // SW stores rt.

    // Word from the last completed read, for LW writeback.
    always_ff @(posedge clk) begin
        if (read && !waitrequest) load_word <= readdata;
    end

    mips_control #(.RESET_VECTOR(RESET_VECTOR)) u_control (
        .clk, .rst, .waitrequest, .readdata, .address, .read, .write, .byteenable,
        .rs_addr, .rt_addr, .rs_data, .rt_data, .alu_op, .alu_src_imm, .imm_zero_ext,
        .alu_zero, .alu_result, .wr_en, .wr_addr, .wr_from_mem, .ir, .active
    );

    mips_regfile u_regfile (
        .clk, .rst, .rs_addr, .rt_addr, .wr_addr, .wr_en, .wr_data,
        .rs_data, .rt_data, .v0(register_v0)
    );

    mips_alu u_alu (
        .a(rs_data), .b(alu_b), .shamt(ir[shamt_lsb +: 5]), .op(alu_op),
        .result(alu_result), .zero(alu_zero)
    );

endmodule

// ==== verilog/avalon_ram.sv ====
`timescale 1ns/10ps

module avalon_ram #(
    parameter int MEM_WORDS   = mips_bus_pkg::mem_words_default,
    parameter int WAIT_CYCLES = 1
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mips_bus_pkg::addr_width-1:0] address,
    input  logic                                read,
    input  logic                                write,
    input  logic [mips_bus_pkg::data_width-1:0] writedata,
    input  logic [mips_bus_pkg::be_width-1:0]   byteenable,
    output logic                                waitrequest,
    output logic [mips_bus_pkg::data_width-1:0] readdata,
    input  logic                                load_en,
    input  logic [7:0]                          load_addr,
    input  logic [31:0]                         load_data
);
    import mips_bus_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(WAIT_CYCLES + 2);

    logic [data_width-1:0] mem [MEM_WORDS];
    logic [AW-1:0]         word_idx;
    logic [CW-1:0]         wait_cnt;
    logic                  access;

    assign access      = read || write;
    assign word_idx    = AW'(address[addr_width-1:2] % MEM_WORDS);
    assign waitrequest = access && (wait_cnt != CW'(WAIT_CYCLES));
    assign readdata    = mem[word_idx];  // Valid in the completing cycle.

    // Counts stall cycles and restarts after each completed access.
    always_ff @(posedge clk) begin
        if (rst || !waitrequest) wait_cnt <= '0;
        else wait_cnt <= wait_cnt + CW'(1);
    end

    always_ff @(posedge clk) begin
        if (write && !waitrequest) begin
            for (int b = 0; b < be_width; b++) begin
                if (byteenable[b]) mem[word_idx][8*b +: 8] <= writedata[8*b +: 8];
            end
        end
        if (load_en) mem[AW'(load_addr[7:2])] <= load_data;  // Program load.
    end

endmodule

// ==== verilog/mips_system.sv ====
`timescale 1ns/10ps

module mips_system #(
    parameter logic [31:0] RESET_VECTOR = 32'd4,
    parameter int          MEM_WORDS    = mips_bus_pkg::mem_words_default,
    parameter int          WAIT_CYCLES  = 1
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        load_en,
    input  logic [7:0]  load_addr,
    input  logic [31:0] load_data,
    output logic        active,
    output logic [31:0] register_v0
);
    import mips_bus_pkg::*;

    // Avalon-MM between processor and RAM.
    logic [addr_width-1:0] address;
    logic                  read, write, waitrequest;
    logic [data_width-1:0] writedata, readdata;
    logic [be_width-1:0]   byteenable;

    mips_cpu #(.RESET_VECTOR(RESET_VECTOR)) u_cpu (
        .clk, .rst, .active, .register_v0, .address, .read, .write,
        .writedata, .byteenable, .waitrequest, .readdata
    );

    avalon_ram #(.MEM_WORDS(MEM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) u_ram (
        .clk, .rst, .address, .read, .write, .writedata, .byteenable,
        .waitrequest, .readdata, .load_en, .load_addr, .load_data
    );

endmodule

// ==== test/mips_system_tb.sv ====
`timescale 1ns/10ps

module mips_system_tb;

    localparam int max_words      = 10;   // One load per reset cycle.
    localparam int reset_cycles   = 10;
    localparam int timeout_cycles = 500;

    logic        clk;
    logic        rst;
    logic        load_en;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        active;
    logic [31:0] register_v0;

    // Program image of the current case.
    logic [7:0]  prog_addr [max_words];
    logic [31:0] prog_word [max_words];
    int          prog_len;
    int          case_num;
    int          cases_run;

    mips_system u_mips_system (
        .clk, .rst, .load_en, .load_addr, .load_data, .active, .register_v0
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // ############################################################
    // Checking helpers.
    // ############################################################
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error at %0t: %s expected 0x%08h, got 0x%08h",
                                        $time, name, expected, actual));
        end
    endtask

    // ############################################################
    // Case sequencing.
    // ############################################################
    // Holds reset while the load port writes one program word per cycle.
    task automatic load_program();
        for (int i = 0; i < reset_cycles; i++) begin
            @(posedge clk);
            #2;
            rst = 1'b1;
            if (i < prog_len) begin
                load_en   = 1'b1;
                load_addr = prog_addr[i];
                load_data = prog_word[i];
            end else begin
                load_en = 1'b0;
            end
        end
        @(posedge clk);
        #2;
        rst     = 1'b0;
        load_en = 1'b0;
    endtask

    // The falling edge of active ends the program.
    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (active) begin
            if (cycles == timeout_cycles) begin
                stop_with_failure($sformatf("Timeout: case %0d did not halt within %0d cycles",
                                            case_num, timeout_cycles));
            end
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic run_case(input logic [31:0] expected);
        load_program();
        check_value("active", 32'd1, {31'b0, active});  // Running after reset.
        wait_for_halt();
        check_value("register_v0", expected, register_v0);
        $display("Case %0d: register_v0 = 0x%08h", case_num, register_v0);
        cases_run++;
    endtask

    // ############################################################
    // Trace reader.
    // ############################################################
    initial begin
        int          fd;
        int          rc;
        string       tok;
        string       rest;
        logic [7:0]  addr;
        logic [31:0] value;

        $timeformat(-9, 1, " ns", 10);
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = 8'h00;
        load_data = 32'h0;
        prog_len  = 0;
        case_num  = 0;
        cases_run = 0;

        fd = $fopen("test/program_trace.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Could not open test/program_trace.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                rc = $fgets(rest, fd);  // Skip comment line.
            end else if (tok == "case") begin
                rc = $fscanf(fd, "%d", case_num);
                prog_len = 0;
            end else if (tok == "expect") begin
                rc = $fscanf(fd, "%h", value);
                run_case(value);
            end else begin
                if (prog_len == max_words) begin
                    stop_with_failure("A program in the trace has more words than reset cycles");
                end
                rc = $sscanf(tok, "%h", addr);
                rc = $fscanf(fd, "%h", value);
                if (rc != 1) begin
                    stop_with_failure("The trace has an address without a program word");
                end
                prog_addr[prog_len] = addr;
                prog_word[prog_len] = value;
                prog_len++;
            end
        end
        $fclose(fd);

        if (cases_run == 0) begin
            stop_with_failure("No test case was read from the trace file");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== verilog.f ====
verilog/mips_isa_pkg.sv
verilog/mips_bus_pkg.sv
verilog/mips_alu.sv
verilog/mips_regfile.sv
verilog/mips_control.sv
verilog/mips_cpu.sv
verilog/avalon_ram.sv
verilog/mips_system.sv
test/mips_system_tb.sv

// ==== Makefile ====
# Verilator build and run of the MIPS system testbench.

SOURCES := $(shell grep -v '^+' verilog.f)
SIM     := obj_dir/Vmips_system_tb

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a listed source changes.
$(SIM): verilog.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module mips_system_tb -f verilog.f

# The log decides pass or fail.
run: $(SIM) test/program_trace.txt
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/program_trace.txt ====
# case <n>, then <byte address> <word> pairs in hex, then expect <$v0 in hex>.
# Programs start at the reset vector 04 and end with jr $0.
case 1
04 24087fff 08 00084100 0c 3c02ffff 10 34425678
14 00481021 18 2442ffff 1c 00021102 20 00000008
expect 00007566
case 2
04 2408fffb 08 24090003 0c 0109502a 10 01091026
14 004a1025 18 00491023 1c 00481024 20 00000008
expect fffffff2
case 3
04 8c020040 08 00000008 40 deadbeef
expect deadbeef
case 4
04 3c08cafe 08 35080123 0c 24090080 10 ad280004
14 8c020084 18 00000008 84 11111111
expect cafe0123
case 5
04 24080005 08 11000001 0c 24020003 10 14400001 14 24020bad
18 15080001 1c 24420010 20 10420001 24 24020bad 28 00000008
expect 00000013
case 6
04 24020055 08 24001234 0c 00001021 10 00000008
expect 00000000
